/* design/btac_pkg.sv */
package btac_pkg;

  // ########################################
  // Sizes

  localparam int lane_count = 2;          // Fetch slots per cycle
  localparam int btb_entries = 64;
  localparam int btb_index_width = 6;     // PC bits 7 down to 2

  // ########################################
  // Vector types

  typedef logic [31:0] addr_t;
  typedef logic [btb_index_width-1:0] btb_index_t;

  // ########################################
  // Table and lane records

  typedef struct packed {
    addr_t pc;                            // Branch PC, used as the tag
    addr_t target;
    addr_t npc;                           // Next sequential PC
  } btb_entry_t;

  typedef struct packed {
    logic enable;
    btb_index_t address;
    btb_entry_t entry;
  } btb_write_t;

  typedef struct packed {
    logic jal;
    logic branch;
    logic jump;                           // Resolved as taken
    addr_t pc;
    addr_t addr;                          // Resolved target
    addr_t npc;
  } upd_t;

  typedef struct packed {
    logic hit;
    btb_entry_t entry;
  } lane_hit_t;

  // ########################################
  // Ports of the top level

  typedef struct packed {
    logic clear;
    addr_t [lane_count-1:0] get_pc;
    upd_t [lane_count-1:0] upd;
    logic taken;                          // Fetch redirected on a prediction
    addr_t taddr;
    addr_t tpc;
  } btac_in_t;

  typedef struct packed {
    logic pred_branch;
    addr_t pred_baddr;
    addr_t pred_pc;
    logic pred_miss;
    addr_t pred_maddr;
  } btac_out_t;

  typedef enum logic {
    idle,
    pending
  } pending_state_t;

endpackage

/* design/btb_lane.sv */
module btb_lane (
  input logic clock,
  input logic reset,
  input btac_pkg::btb_write_t write,
  input btac_pkg::addr_t get_pc,
  output btac_pkg::lane_hit_t lane_hit
);

  btac_pkg::btb_entry_t entries [btac_pkg::btb_entries];
  logic [btac_pkg::btb_entries-1:0] valid;
  btac_pkg::btb_index_t read_index;
  btac_pkg::btb_entry_t read_entry;

  // ########################################
  // Storage

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid <= '0;
    end else if (write.enable) begin
      valid[write.address] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write.enable) begin
      entries[write.address] <= write.entry;  // Same data in every lane
    end
  end

  // ########################################
  // Lookup

  assign read_index = get_pc[btac_pkg::btb_index_width+1:2];
  assign read_entry = entries[read_index];    // Asynchronous read

  // Full PC compare, so aliased indices never hit
  assign lane_hit.hit = valid[read_index] && (read_entry.pc == get_pc);
  assign lane_hit.entry = read_entry;

  // The update block must settle its index before any enabled write
  write_address_known : assert property (
    @(posedge clock) disable iff (!reset)
    write.enable |-> !$isunknown(write.address)
  );

endmodule

/* design/btac_update.sv */
module btac_update (
  input logic clear,
  input btac_pkg::upd_t [btac_pkg::lane_count-1:0] upd,
  output btac_pkg::btb_write_t write
);

  // ########################################
  // Learning policy
  //
  // Any lane that resolves a taken jal or branch triggers a write.
  // The entry comes from the lowest lane with jump set; with no such
  // lane the last lane supplies it.

  always_comb begin : select_write
    logic learn;
    btac_pkg::upd_t chosen;

    learn = 1'b0;
    chosen = upd[btac_pkg::lane_count-1];

    for (int i = btac_pkg::lane_count - 1; i >= 0; i--) begin
      learn = learn | ((upd[i].jal | upd[i].branch) & upd[i].jump);
      if (upd[i].jump) begin
        chosen = upd[i];                    // Lower lane wins
      end
    end

    write.enable = learn;
    write.address = chosen.pc[btac_pkg::btb_index_width+1:2];
    write.entry.pc = chosen.pc;
    write.entry.target = chosen.addr;
    write.entry.npc = chosen.npc;

    if (clear) begin
      write = '0;                           // Flushed updates are not learned
    end
  end

endmodule

/* design/btac_resolve.sv */
module btac_resolve (
  input logic clock,
  input logic reset,
  input logic clear,
  input btac_pkg::lane_hit_t [btac_pkg::lane_count-1:0] lane_hit,
  input btac_pkg::upd_t [btac_pkg::lane_count-1:0] upd,
  input logic taken,
  input btac_pkg::addr_t taddr,
  input btac_pkg::addr_t tpc,
  output btac_pkg::btac_out_t result
);

  btac_pkg::pending_state_t state;
  btac_pkg::pending_state_t state_next;
  btac_pkg::pending_state_t cur_state;
  btac_pkg::addr_t held_taddr;
  btac_pkg::addr_t held_tpc;
  btac_pkg::addr_t cur_taddr;
  btac_pkg::addr_t cur_tpc;

  logic hit_any;
  btac_pkg::btb_entry_t hit_entry;
  logic miss;
  btac_pkg::addr_t maddr;
  logic resolved;

  // ########################################
  // Prediction

  always_comb begin : pick_lane
    hit_any = 1'b0;
    hit_entry = '0;
    for (int i = btac_pkg::lane_count - 1; i >= 0; i--) begin
      if (lane_hit[i].hit) begin
        hit_any = 1'b1;
        hit_entry = lane_hit[i].entry;    // Lowest hitting lane last
      end
    end
  end

  // ########################################
  // Taken tracker and miss detection

  always_comb begin : tracker
    cur_state = state;
    cur_taddr = held_taddr;
    cur_tpc = held_tpc;
    if (taken) begin
      cur_state = btac_pkg::pending;      // Used in this same cycle
      cur_taddr = taddr;
      cur_tpc = tpc;
    end

    miss = 1'b0;
    maddr = '0;
    resolved = 1'b0;

    for (int i = btac_pkg::lane_count - 1; i >= 0; i--) begin
      if (cur_state == btac_pkg::idle) begin
        if (upd[i].jump) begin
          miss = 1'b1;                    // Unpredicted taken jump
          maddr = upd[i].addr;
        end
      end else if (upd[i].jump) begin
        miss = (upd[i].addr != cur_taddr);
        maddr = upd[i].addr;
        resolved = 1'b1;
      end else if (upd[i].branch) begin
        miss = 1'b1;                      // Predicted taken but fell through
        maddr = cur_tpc;
        resolved = 1'b1;
      end
    end

    if (cur_state == btac_pkg::pending && !resolved) begin
      state_next = btac_pkg::pending;
    end else begin
      state_next = btac_pkg::idle;
    end

    if (clear) begin
      miss = 1'b0;
      maddr = '0;
      state_next = btac_pkg::idle;        // Drop the pending prediction
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= btac_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (taken && !clear) begin
      held_taddr <= taddr;
      held_tpc <= tpc;
    end
  end

  // ########################################
  // Outputs

  always_comb begin : drive_result
    result = '0;
    if (!clear) begin
      result.pred_branch = hit_any;
      result.pred_baddr = hit_entry.target;
      result.pred_pc = hit_entry.pc;
    end
    result.pred_miss = miss;
    result.pred_maddr = maddr;
  end

  // Lane 0 wins whenever it hits
  lane0_hit_reported : assert property (
    @(posedge clock) disable iff (!reset)
    (!clear && lane_hit[0].hit) |->
      (result.pred_branch && result.pred_pc == lane_hit[0].entry.pc)
  );

endmodule

/* design/btac.sv */
module btac (
  input logic clock,
  input logic reset,
  input btac_pkg::btac_in_t btac_in,
  output btac_pkg::btac_out_t btac_out
);

  btac_pkg::btb_write_t write;
  btac_pkg::lane_hit_t [btac_pkg::lane_count-1:0] lane_hit;

  // ########################################
  // Table write selection

  btac_update i_update (
    .clear (btac_in.clear),
    .upd   (btac_in.upd),
    .write (write)
  );

  // ########################################
  // Lookup lanes, one table copy per fetch slot

  for (genvar i = 0; i < btac_pkg::lane_count; i++) begin : g_lane
    btb_lane i_lane (
      .clock    (clock),
      .reset    (reset),
      .write    (write),                  // Shared by all lanes
      .get_pc   (btac_in.get_pc[i]),
      .lane_hit (lane_hit[i])
    );
  end

  // ########################################
  // Prediction and redirect

  btac_resolve i_resolve (
    .clock    (clock),
    .reset    (reset),
    .clear    (btac_in.clear),
    .lane_hit (lane_hit),
    .upd      (btac_in.upd),
    .taken    (btac_in.taken),
    .taddr    (btac_in.taddr),
    .tpc      (btac_in.tpc),
    .result   (btac_out)
  );

endmodule

/* bench/btac_ref.svh */
// ########################################
// Shadow table and taken tracker

logic model_valid [btac_pkg::btb_entries];
btac_pkg::addr_t model_pc [btac_pkg::btb_entries];
btac_pkg::addr_t model_target [btac_pkg::btb_entries];
btac_pkg::pending_state_t model_state;
btac_pkg::addr_t model_taddr;
btac_pkg::addr_t model_tpc;

function automatic void reset_model();
  for (int i = 0; i < btac_pkg::btb_entries; i++) begin
    model_valid[i] = 1'b0;
  end
  model_state = btac_pkg::idle;
endfunction

function automatic btac_pkg::btac_out_t expected_out(btac_pkg::btac_in_t cur);
  btac_pkg::btac_out_t want;
  btac_pkg::btb_index_t idx;
  logic pending_now;
  logic decided;
  btac_pkg::addr_t ref_taddr;
  btac_pkg::addr_t ref_tpc;

  want = '0;
  pending_now = cur.taken || (model_state == btac_pkg::pending);
  ref_taddr = cur.taken ? cur.taddr : model_taddr;  // Taken input counts this cycle
  ref_tpc = cur.taken ? cur.tpc : model_tpc;

  for (int i = 0; i < btac_pkg::lane_count; i++) begin
    idx = cur.get_pc[i][7:2];
    if (!want.pred_branch && model_valid[idx] && model_pc[idx] == cur.get_pc[i]) begin
      want.pred_branch = 1'b1;                       // First hitting lane
      want.pred_baddr = model_target[idx];
      want.pred_pc = model_pc[idx];
    end
  end

  decided = 1'b0;
  for (int i = 0; i < btac_pkg::lane_count; i++) begin
    if (!decided && cur.upd[i].jump) begin
      decided = 1'b1;
      want.pred_maddr = cur.upd[i].addr;
      want.pred_miss = pending_now ? (cur.upd[i].addr != ref_taddr) : 1'b1;
    end else if (!decided && pending_now && cur.upd[i].branch) begin
      decided = 1'b1;
      want.pred_maddr = ref_tpc;                     // Predicted taken but fell through
      want.pred_miss = 1'b1;
    end
  end

  if (cur.clear) begin
    want = '0;
  end
  return want;
endfunction

function automatic void advance_model(btac_pkg::btac_in_t cur);
  btac_pkg::upd_t src;
  logic learn_any;
  logic settled;
  logic pending_now;

  learn_any = 1'b0;
  settled = 1'b0;
  for (int i = 0; i < btac_pkg::lane_count; i++) begin
    learn_any |= (cur.upd[i].jal | cur.upd[i].branch) & cur.upd[i].jump;
    settled |= cur.upd[i].jump | cur.upd[i].branch;
  end
  src = cur.upd[0].jump ? cur.upd[0] : cur.upd[1];
  pending_now = cur.taken || (model_state == btac_pkg::pending);

  if (cur.clear) begin
    model_state = btac_pkg::idle;
  end else begin
    if (learn_any) begin
      model_valid[src.pc[7:2]] = 1'b1;
      model_pc[src.pc[7:2]] = src.pc;
      model_target[src.pc[7:2]] = src.addr;
    end
    if (cur.taken) begin
      model_taddr = cur.taddr;
      model_tpc = cur.tpc;
    end
    if (pending_now && !settled) begin
      model_state = btac_pkg::pending;
    end else begin
      model_state = btac_pkg::idle;
    end
  end
endfunction

/* bench/btac_tb.sv */
module btac_tb;

  localparam int clock_period = 20;
  localparam int seq_cycles = 8 + 17 + 4 + 4 + 13 + 7;  // Empty, learn, alias, idle, taken, clear
  localparam int cycle_limit = 2 * (2 + seq_cycles);

  logic clock;
  logic reset;
  btac_pkg::btac_in_t btac_in;
  btac_pkg::btac_out_t btac_out;

  integer seed = 32'h73fde60b;
  int check_count = 0;
  int error_count = 0;
  int cycles = 0;

  `include "btac_ref.svh"

  btac i_btac (
    .clock    (clock),
    .reset    (reset),
    .btac_in  (btac_in),
    .btac_out (btac_out)
  );

  initial begin : clock_gen
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // ########################################
  // Stimulus helpers

  function automatic btac_pkg::addr_t rand_pc();
    btac_pkg::addr_t pc;
    pc = $random(seed);
    pc[1:0] = 2'b00;
    return pc;
  endfunction

  function automatic btac_pkg::addr_t pc_at(int index);
    btac_pkg::addr_t pc;
    pc = $random(seed);
    pc[7:0] = {index[5:0], 2'b00};                      // Fixed table index
    return pc;
  endfunction

  function automatic btac_pkg::upd_t resolved_upd(logic is_branch, logic jump,
                                                  btac_pkg::addr_t pc, btac_pkg::addr_t target);
    btac_pkg::upd_t u;
    u = '0;
    u.jal = !is_branch;
    u.branch = is_branch;
    u.jump = jump;
    u.pc = pc;
    u.addr = target;
    u.npc = pc + 4;
    return u;
  endfunction

  task automatic apply(input btac_pkg::btac_in_t v);
    btac_in = v;
    @(posedge clock);
    #2;
  endtask

  task automatic lookup(input btac_pkg::addr_t pc0, input btac_pkg::addr_t pc1);
    btac_pkg::btac_in_t v;
    v = '0;
    v.get_pc[0] = pc0;
    v.get_pc[1] = pc1;
    apply(v);
  endtask

  task automatic resolve_lane(input int lane, input logic is_branch, input logic jump,
                              input btac_pkg::addr_t pc, input btac_pkg::addr_t target);
    btac_pkg::btac_in_t v;
    v = '0;
    v.upd[lane] = resolved_upd(is_branch, jump, pc, target);
    apply(v);
  endtask

  task automatic predict_taken(input btac_pkg::addr_t taddr, input btac_pkg::addr_t tpc);
    btac_pkg::btac_in_t v;
    v = '0;
    v.taken = 1'b1;
    v.taddr = taddr;
    v.tpc = tpc;
    apply(v);
  endtask

  task automatic compare_field(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // ########################################
  // Checking

  initial begin : compare_outputs
    btac_pkg::btac_in_t sampled;
    btac_pkg::btac_out_t want;
    logic sampled_reset;

    reset_model();
    @(posedge clock);
    forever begin
      #(clock_period - 1);                             // Just before the next edge
      sampled = btac_in;
      sampled_reset = reset;
      if (sampled_reset) begin
        want = expected_out(sampled);
        compare_field("pred_branch", btac_out.pred_branch, want.pred_branch);
        compare_field("pred_baddr", btac_out.pred_baddr, want.pred_baddr);
        compare_field("pred_pc", btac_out.pred_pc, want.pred_pc);
        compare_field("pred_miss", btac_out.pred_miss, want.pred_miss);
        compare_field("pred_maddr", btac_out.pred_maddr, want.pred_maddr);
      end
      @(posedge clock);
      if (sampled_reset) begin
        advance_model(sampled);
      end else begin
        reset_model();
      end
    end
  end

  initial begin : watchdog
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

  // ########################################
  // Sequences

  initial begin : stimulus
    btac_pkg::addr_t pcs [4];
    btac_pkg::addr_t alias_pc;
    btac_pkg::addr_t target;
    btac_pkg::btac_in_t v;

    btac_in = '0;
    reset = 1'b0;
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b1;

    repeat (8) lookup(rand_pc(), rand_pc());           // Empty table

    for (int k = 0; k < 4; k++) begin
      pcs[k] = pc_at(5 * k + 1);
      resolve_lane(k % 2, 1'b0, 1'b1, pcs[k], rand_pc());
      lookup(pcs[k], rand_pc());
      lookup(rand_pc(), pcs[k]);
    end
    lookup(pcs[0], pcs[1]);                            // Both hit, lane 0 reported
    lookup(pcs[3], pcs[2]);
    v = '0;
    v.upd[0] = resolved_upd(1'b1, 1'b1, pc_at(40), rand_pc());
    v.upd[1] = resolved_upd(1'b0, 1'b1, pc_at(41), rand_pc());
    apply(v);                                          // Only lane 0 learned
    lookup(v.upd[0].pc, v.upd[1].pc);
    lookup(v.upd[1].pc, v.upd[0].pc);

    alias_pc = pcs[2] ^ 32'h0010_0000;                 // Same index, other tag
    lookup(alias_pc, alias_pc);
    resolve_lane(1, 1'b1, 1'b1, alias_pc, rand_pc());
    lookup(alias_pc, pcs[2]);
    lookup(pcs[2], rand_pc());

    v = '0;
    v.upd[1] = resolved_upd(1'b1, 1'b1, pc_at(50), rand_pc());
    apply(v);                                          // Idle miss on lane 1
    v.upd[0] = resolved_upd(1'b0, 1'b1, pc_at(51), rand_pc());
    apply(v);
    v.upd[0].jump = 1'b0;
    v.upd[1].jump = 1'b0;
    apply(v);
    apply('0);

    target = rand_pc();
    v = '0;
    v.taken = 1'b1;
    v.taddr = target;
    v.tpc = pc_at(20);
    v.upd[0] = resolved_upd(1'b1, 1'b1, v.tpc, target);
    apply(v);                                          // Resolved in the taken cycle
    predict_taken(rand_pc(), pc_at(21));
    apply('0);
    resolve_lane(1, 1'b1, 1'b1, pc_at(21), rand_pc());  // Wrong target
    predict_taken(rand_pc(), pc_at(22));
    apply('0);
    resolve_lane(0, 1'b1, 1'b0, pc_at(22), rand_pc());  // Not taken after all
    target = rand_pc();
    predict_taken(target, pc_at(23));
    repeat (3) apply('0);
    resolve_lane(0, 1'b1, 1'b1, pc_at(23), target);
    resolve_lane(1, 1'b0, 1'b1, pc_at(24), rand_pc());

    v = '0;
    v.clear = 1'b1;
    v.get_pc[0] = pcs[0];
    v.get_pc[1] = pcs[1];
    v.upd[0] = resolved_upd(1'b0, 1'b1, pc_at(60), rand_pc());
    apply(v);
    lookup(v.upd[0].pc, pcs[0]);                       // Flushed update not learned
    predict_taken(rand_pc(), pc_at(25));
    v = '0;
    v.clear = 1'b1;
    apply(v);
    resolve_lane(0, 1'b1, 1'b0, pc_at(25), rand_pc());
    target = rand_pc();
    v.taken = 1'b1;
    v.taddr = target;
    v.tpc = pc_at(26);
    apply(v);                                          // Taken together with clear
    resolve_lane(0, 1'b0, 1'b1, pc_at(26), target);

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
design/btac_pkg.sv
design/btb_lane.sv
design/btac_update.sv
design/btac_resolve.sv
design/btac.sv
bench/btac_tb.sv

/* Bender.yml */
package:
  name: btac

sources:
  - design/btac_pkg.sv
  - design/btb_lane.sv
  - design/btac_update.sv
  - design/btac_resolve.sv
  - design/btac.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/btac_tb.sv
